//--- design/issue_stage_cfg.svh
// issue stage configuration
// queue depth, physical register count and field widths

`ifndef ISSUE_STAGE_CFG_SVH
`define ISSUE_STAGE_CFG_SVH

// issue queue depth and entry index width
`define IQ_ENTRIES 4
`define IQ_IDX_W   2

// physical register file size
`define PREG_NUM   32
`define PREG_W     5

// alu function code width
`define ALU_OP_W   4

`endif

//--- design/issue_pkg.sv
// issue stage types
// width typedefs plus the uop and queue entry records

`include "issue_stage_cfg.svh"

package issue_pkg;

    // physical register number
    typedef logic [`PREG_W-1:0] preg_t;

    // alu function code
    typedef logic [`ALU_OP_W-1:0] alu_op_t;

    // slot index inside the issue queue
    typedef logic [`IQ_IDX_W-1:0] iq_idx_t;

    // age rank, 0 is the oldest waiting entry
    typedef logic [`IQ_IDX_W-1:0] iq_rank_t;

    // renamed alu instruction as it arrives and as it leaves
    typedef struct packed {
        alu_op_t op;
        preg_t   src1;
        preg_t   src2;
        preg_t   dst;
    } iq_uop_t;

    // one queue slot
    typedef struct packed {
        iq_uop_t  uop;
        logic     ready1;   // src1 result available
        logic     ready2;   // src2 result available
        iq_rank_t rank;
        logic     valid;
    } iq_entry_t;

endpackage

//--- design/reg_ready_table.sv
// register ready table (scoreboard)
// one ready bit per physical register, with same-edge wakeup bypass on reads

`timescale 1ns/1ns

`include "issue_stage_cfg.svh"

module reg_ready_table
    import issue_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    // read ports for the incoming uop
    input  preg_t src1,
    input  preg_t src2,
    output logic  rdy1,
    output logic  rdy2,
    // rename of a new destination
    input  logic  alloc,
    input  preg_t alloc_reg,
    // result of an issued uop becomes available
    input  logic  wake,
    input  preg_t wake_reg
);

    logic [`PREG_NUM-1:0] ready_bits;

    // all registers hold committed values out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ready_bits <= '1;
        end else begin
            // renamer never hands out a register that is still pending,
            // so alloc and wake never hit the same bit
            if (alloc) begin
                ready_bits[alloc_reg] <= 1'b0;
            end
            if (wake) begin
                ready_bits[wake_reg] <= 1'b1;
            end
        end
    end

    // bypass: a register woken at this edge already counts as ready
    assign rdy1 = ready_bits[src1] | (wake && (wake_reg == src1));
    assign rdy2 = ready_bits[src2] | (wake && (wake_reg == src2));

endmodule

//--- design/iq_age_select.sv
// issue queue select logic
// picks the oldest valid entry with both sources ready

`timescale 1ns/1ns

`include "issue_stage_cfg.svh"

module iq_age_select
    import issue_pkg::*;
(
    input  iq_entry_t entries [`IQ_ENTRIES],
    output logic      pick_valid,
    output iq_idx_t   pick_idx
);

    // per-slot eligibility
    logic [`IQ_ENTRIES-1:0] cand;

    // rank of the best candidate seen so far
    iq_rank_t best_rank;

    always_comb begin
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            cand[i] = entries[i].valid && entries[i].ready1 && entries[i].ready2;
        end
    end

    // linear scan keeping the lowest rank
    // ranks of valid entries are unique, so no tie break is needed
    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = '0;
        best_rank  = '0;
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            if (cand[i]) begin
                if (!pick_valid || (entries[i].rank < best_rank)) begin
                    pick_valid = 1'b1;
                    pick_idx   = iq_idx_t'(i);
                    best_rank  = entries[i].rank;
                end
            end
        end
    end

endmodule

//--- design/issue_queue.sv
// alu issue queue
// holds renamed uops, tracks source readiness and age,
// issues the oldest ready uop and broadcasts its destination for wakeup

`timescale 1ns/1ns

`include "issue_stage_cfg.svh"

module issue_queue
    import issue_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    // dispatch side
    input  logic    load,
    input  iq_uop_t uop,
    // issue unit side
    input  logic    issue,
    // scoreboard reads for the incoming sources, bypass included
    input  logic    rdy1,
    input  logic    rdy2,
    // scoreboard updates
    output logic    alloc,
    output preg_t   alloc_reg,
    output logic    wake,
    output preg_t   wake_reg,
    // issue result
    output logic    issue_ready,
    output iq_uop_t issued,
    output logic    full
);

    iq_entry_t entries     [`IQ_ENTRIES];
    iq_entry_t entries_nxt [`IQ_ENTRIES];

    logic [`IQ_ENTRIES-1:0] valid_nxt;

    // occupancy, needs one bit more than an index
    logic [`IQ_IDX_W:0] valid_cnt;

    logic     pick_valid;
    iq_idx_t  pick_idx;
    iq_rank_t pick_rank;
    iq_idx_t  free_idx;
    iq_rank_t load_rank;

    logic do_load;
    logic do_issue;

    iq_age_select u_select (
        .entries    (entries),
        .pick_valid (pick_valid),
        .pick_idx   (pick_idx)
    );

    // full refuses a load even when a slot frees at this edge
    assign do_load  = load && !full;

    // one pulse per request: the cycle showing issue_ready does not issue again
    assign do_issue = issue && pick_valid && !issue_ready;

    assign pick_rank = entries[pick_idx].rank;

    // lowest free slot
    always_comb begin
        free_idx = '0;
        for (int i = `IQ_ENTRIES - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                free_idx = iq_idx_t'(i);
            end
        end
    end

    always_comb begin
        valid_cnt = '0;
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            valid_cnt = valid_cnt + entries[i].valid;
        end
    end

    // new entry is younger than all survivors
    assign load_rank = iq_rank_t'(valid_cnt - do_issue);

    // scoreboard handshake
    assign alloc     = do_load;
    assign alloc_reg = uop.dst;
    assign wake      = do_issue;
    assign wake_reg  = entries[pick_idx].uop.dst;

    // next state of the entry array
    always_comb begin
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            entries_nxt[i] = entries[i];
            if (do_issue && entries[i].valid) begin
                if (iq_idx_t'(i) == pick_idx) begin
                    entries_nxt[i].valid = 1'b0;
                end else begin
                    // close the gap left by the issued entry
                    if (entries[i].rank > pick_rank) begin
                        entries_nxt[i].rank = entries[i].rank - 1'b1;
                    end
                    // wakeup broadcast
                    if (entries[i].uop.src1 == wake_reg) begin
                        entries_nxt[i].ready1 = 1'b1;
                    end
                    if (entries[i].uop.src2 == wake_reg) begin
                        entries_nxt[i].ready2 = 1'b1;
                    end
                end
            end
        end
        // free slot is never the picked one, the queue was not full
        if (do_load) begin
            entries_nxt[free_idx] = '{
                uop:    uop,
                ready1: rdy1,
                ready2: rdy2,
                rank:   load_rank,
                valid:  1'b1
            };
        end
    end

    always_comb begin
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            valid_nxt[i] = entries_nxt[i].valid;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `IQ_ENTRIES; i++) begin
                entries[i] <= '0;
            end
            full <= 1'b0;
        end else begin
            for (int i = 0; i < `IQ_ENTRIES; i++) begin
                entries[i] <= entries_nxt[i];
            end
            full <= &valid_nxt;
        end
    end

    // registered issue output, held until the next issue
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_ready <= 1'b0;
            issued      <= '0;
        end else begin
            issue_ready <= do_issue;
            if (do_issue) begin
                issued <= entries[pick_idx].uop;
            end
        end
    end

endmodule

//--- design/issue_stage.sv
// issue stage top level
// issue queue plus the physical register ready table

`timescale 1ns/1ns

module issue_stage
    import issue_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    load,
    input  iq_uop_t uop,
    input  logic    issue,
    output logic    issue_ready,
    output iq_uop_t issued,
    output logic    full
);

    logic  rdy1;
    logic  rdy2;
    logic  alloc;
    preg_t alloc_reg;
    logic  wake;
    preg_t wake_reg;

    issue_queue u_queue (
        .clk         (clk),
        .reset       (reset),
        .load        (load),
        .uop         (uop),
        .issue       (issue),
        .rdy1        (rdy1),
        .rdy2        (rdy2),
        .alloc       (alloc),
        .alloc_reg   (alloc_reg),
        .wake        (wake),
        .wake_reg    (wake_reg),
        .issue_ready (issue_ready),
        .issued      (issued),
        .full        (full)
    );

    // read ports look up the sources of the uop being dispatched
    reg_ready_table u_ready (
        .clk       (clk),
        .reset     (reset),
        .src1      (uop.src1),
        .src2      (uop.src2),
        .rdy1      (rdy1),
        .rdy2      (rdy2),
        .alloc     (alloc),
        .alloc_reg (alloc_reg),
        .wake      (wake),
        .wake_reg  (wake_reg)
    );

endmodule

//--- bench/issue_stage_sva.sv
// issue stage protocol checks
// bound onto the issue stage top level

`timescale 1ns/1ns

module issue_stage_sva (
    input logic clk,
    input logic reset,
    input logic load,
    input logic issue,
    input logic issue_ready,
    input logic full
);

    // one pulse per issue
    assert property (@(posedge clk) disable iff (reset) issue_ready |=> !issue_ready)
        else $error("issue_ready high for two cycles");

    // a pulse only answers a held request
    assert property (@(posedge clk) disable iff (reset) issue_ready |-> $past(issue))
        else $error("issue_ready without a preceding issue");

    // refused load with no issue leaves occupancy unchanged
    assert property (@(posedge clk) disable iff (reset) full && load && !issue |=> full)
        else $error("full dropped after a refused load");

endmodule

bind issue_stage issue_stage_sva u_sva (
    .clk(clk), .reset(reset), .load(load), .issue(issue),
    .issue_ready(issue_ready), .full(full)
);

//--- bench/issue_stage_tb.sv
// issue stage testbench
// directed and random dispatch/issue traffic checked against a reference model

`timescale 1ns/1ns

`include "issue_stage_cfg.svh"

module issue_stage_tb
    import issue_pkg::*;
();

    logic    clk;
    logic    reset;
    logic    load;
    iq_uop_t uop;
    logic    issue;
    logic    issue_ready;
    iq_uop_t issued;
    logic    full;

    integer  seed = 90548;
    int      held = 0;

    // shadow of the pending uops in load order, the ready table and the expected outputs
    iq_uop_t pend [$];
    bit      rt [`PREG_NUM] = '{default: 1'b1};
    bit      exp_ready = 1'b0;
    bit      exp_full = 1'b0;
    iq_uop_t exp_issued = '0;

    issue_stage UUT (.clk(clk), .reset(reset), .load(load), .uop(uop), .issue(issue),
                     .issue_ready(issue_ready), .issued(issued), .full(full));

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // advances the model by one clock edge with issue applied before load
    function automatic iq_uop_t model_issue(input bit ld, input iq_uop_t u, input bit is);
        int      pick;
        iq_uop_t res;
        pick = -1;
        res  = exp_issued;
        // no issue in the cycle showing issue_ready
        // oldest ready entry wins
        if (is && !exp_ready) begin
            for (int i = pend.size() - 1; i >= 0; i--) begin
                if (rt[pend[i].src1] && rt[pend[i].src2])
                    pick = i;
            end
        end
        exp_ready = (pick >= 0);
        if (pick >= 0) begin
            res = pend[pick];
            // one-cycle alu makes the result ready at the issue edge for a same-edge load
            rt[res.dst] = 1'b1;
            pend.delete(pick);
        end
        // a full queue refuses even if an entry leaves at this edge
        if (ld && !exp_full) begin
            rt[u.dst] = 1'b0;
            pend.push_back(u);
        end
        exp_full = (pend.size() == `IQ_ENTRIES);
        return res;
    endfunction

    // first ready register after a random start
    // a free register is also not named by any pending uop
    function automatic preg_t scan_reg(input bit need_free, input preg_t a, input preg_t b);
        preg_t start;
        preg_t r;
        bit    named;
        start = preg_t'($random(seed));
        for (int k = 0; k < `PREG_NUM; k++) begin
            r     = start + preg_t'(k);
            named = (r == a) || (r == b);
            foreach (pend[i])
                named |= (pend[i].src1 == r) || (pend[i].src2 == r) || (pend[i].dst == r);
            if (rt[r] && !(need_free && named))
                return r;
        end
        return start;
    endfunction

    // renamed uop with ready sources when indep is set
    // otherwise random sources or one on the youngest producer
    function automatic iq_uop_t make_uop(input bit indep);
        iq_uop_t     u;
        logic [31:0] r;
        r    = $random(seed);
        u.op = alu_op_t'(r);
        if (indep) begin
            u.src1 = scan_reg(1'b0, '0, '0);
            u.src2 = scan_reg(1'b0, '0, '0);
        end else begin
            u.src1 = (r[8] && pend.size() > 0) ? pend[pend.size() - 1].dst : preg_t'(r[13:9]);
            u.src2 = preg_t'(r[18:14]);
        end
        u.dst = scan_reg(1'b1, u.src1, u.src2);
        return u;
    endfunction

    task automatic load_one(input iq_uop_t u);
        load = 1'b1;
        uop  = u;
        @(posedge clk);
        #1;
        load = 1'b0;
    endtask

    task automatic wait_issue();
        int n;
        n = 0;
        while (!issue_ready) begin
            assert (n < 40) else report_failure("timeout waiting for issue_ready");
            n++;
            @(posedge clk);
            #1;
        end
    endtask

    // first edge may still be blocked by an earlier pulse
    task automatic issue_one();
        issue = 1'b1;
        @(posedge clk);
        #1;
        wait_issue();
        issue = 1'b0;
    endtask

    // held issue with nothing eligible must stay unanswered
    task automatic hold_idle(input int cycles);
        issue = 1'b1;
        repeat (cycles) begin
            @(posedge clk);
            #1;
            assert (!issue_ready) else report_failure("issue_ready with nothing to issue");
        end
        issue = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!reset)
            exp_issued = model_issue(load, uop, issue);
    end

    // outputs are compared mid cycle after they settle
    always @(negedge clk) begin
        if (!reset) begin
            assert (issue_ready === exp_ready) else report_failure($sformatf(
                "Error t=%0t issue_ready expected %b got %b", $time, exp_ready, issue_ready));
            assert (full === exp_full) else report_failure($sformatf(
                "Error t=%0t full expected %b got %b", $time, exp_full, full));
            assert (issued === exp_issued) else report_failure($sformatf(
                "Error t=%0t issued expected %h got %h", $time, exp_issued, issued));
        end
    end

    initial begin
        iq_uop_t a;
        iq_uop_t b;
        reset = 1'b1;
        load  = 1'b0;
        uop   = '0;
        issue = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        hold_idle(6);
        // four loads fill the queue and the fifth is dropped
        repeat (4) load_one(make_uop(1'b1));
        assert (full) else report_failure($sformatf(
            "Error t=%0t full expected 1 got %b", $time, full));
        load_one(make_uop(1'b1));
        // drain in load order
        repeat (4) issue_one();
        hold_idle(6);
        // consumer waits for its producer
        a = make_uop(1'b1);
        load_one(a);
        b = make_uop(1'b1);
        b.src1 = a.dst;
        load_one(b);
        load_one(make_uop(1'b1));
        repeat (3) issue_one();
        // load on the register woken at this very edge
        a = make_uop(1'b1);
        load_one(a);
        b = make_uop(1'b1);
        b.src2 = a.dst;
        issue = 1'b1;
        load_one(b);
        wait_issue();
        issue_one();
        // random mix
        repeat (600) begin
            load = 1'($random(seed));
            uop  = make_uop(1'b0);
            if (issue_ready)
                issue = 1'b0;
            else if (!issue)
                issue = 1'($random(seed));
            held = issue ? held + 1 : 0;
            assert (held < 64) else report_failure("held issue never answered");
            @(posedge clk);
            #1;
        end
        load = 1'b0;
        if (issue)
            wait_issue();
        issue = 1'b0;
        while (pend.size() > 0)
            issue_one();
        // no uop may be left in the queue after the drain
        hold_idle(6);
        $display("Test OK");
        $finish;
    end

endmodule

//--- compile.f
+incdir+design
design/issue_pkg.sv
design/reg_ready_table.sv
design/iq_age_select.sv
design/issue_queue.sv
design/issue_stage.sv
bench/issue_stage_sva.sv
bench/issue_stage_tb.sv

//--- run.sh
#!/bin/sh
# build and run the issue stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module issue_stage_tb \
    -f compile.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vissue_stage_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
